/* vga_snake_cfg.svh */
// --------------------
// VGA timing counts, tile map geometry
// and bus widths for the snake display
// --------------------
`ifndef VGA_SNAKE_CFG_SVH
`define VGA_SNAKE_CFG_SVH

// horizontal, in 50 MHz clock cycles
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96
`define H_TOTAL 1600

// vertical, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// map in 16x16 pixel tiles
`define MAP_COLS 40
`define MAP_ROWS 30
`define MAP_WORDS 300

`define BUS_ADDR_W 9
`define BUS_DATA_W 32

// counter state to pixel outputs
`define PIPE_DELAY 2

`endif

/* vga_snake_pkg.sv */
// --------------------
// snake display types: beam counts,
// tile codes, map coordinates, colour
// and the tile palette
// --------------------
package vga_snake_pkg;

  // hcount[10:1] is the pixel column
  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;

  typedef logic [7:0] tile_code_t;
  typedef logic [5:0] tile_col_t;
  typedef logic [4:0] tile_row_t;

  localparam tile_code_t TILE_EMPTY = 8'd0;
  localparam tile_code_t TILE_APPLE = 8'd1;
  localparam tile_code_t TILE_HEAD = 8'd2;
  localparam tile_code_t TILE_BODY = 8'd3;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // map tile beats wall, wall beats background
  function automatic rgb_t tile_color(tile_code_t code, logic wall);
    case (code)
      TILE_APPLE: return '{r: 8'd248, g: 8'd0, b: 8'd0};
      TILE_HEAD: return '{r: 8'd0, g: 8'd252, b: 8'd0};
      TILE_BODY: return '{r: 8'd0, g: 8'd128, b: 8'd0};
      default: return wall ? '{r: 8'd128, g: 8'd128, b: 8'd128} : '0;
    endcase
  endfunction

endpackage

/* video_timing_if.sv */
// --------------------
// beam position and sync levels from
// the timing generator to the renderer
// --------------------
`timescale 1ns/1ps

interface video_timing_if;

  vga_snake_pkg::hcount_t hcount;
  vga_snake_pkg::vcount_t vcount;
  logic blank_n;
  logic hs;
  logic vs;

  modport source (
    output hcount, vcount, blank_n, hs, vs
  );

  modport sink (
    input hcount, vcount, blank_n, hs, vs
  );

endinterface

/* vga_timing.sv */
// --------------------
// 640x480 VGA timing at 50 MHz
// beam counters, sync and blank decode
// --------------------
`timescale 1ns/1ps
`include "vga_snake_cfg.svh"

module vga_timing (
  input logic clk,
  input logic reset,
  video_timing_if.source vt
);

  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END = VS_START + `V_SYNC;

  vga_snake_pkg::hcount_t hcount;
  vga_snake_pkg::vcount_t vcount;
  logic end_of_line;
  logic end_of_frame;

  assign end_of_line = (hcount == vga_snake_pkg::hcount_t'(`H_TOTAL - 1));
  assign end_of_frame = (vcount == vga_snake_pkg::vcount_t'(`V_TOTAL - 1));

  // --------------------
  // counters
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // --------------------
  // decode, from registered counts
  assign vt.hcount = hcount;
  assign vt.vcount = vcount;
  assign vt.hs = !(hcount >= HS_START && hcount < HS_END);
  assign vt.vs = !(vcount >= VS_START && vcount < VS_END);
  assign vt.blank_n = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    hcount < `H_TOTAL && vcount < `V_TOTAL);

endmodule

/* tile_map.sv */
// --------------------
// tile map, 40x30 codes in 300 words
// bus word writes, registered tile read
// --------------------
`timescale 1ns/1ps
`include "vga_snake_cfg.svh"

module tile_map (
  input logic clk,
  input logic reset,
  input logic chipselect,
  input logic write,
  input logic [`BUS_ADDR_W-1:0] address,
  input logic [`BUS_DATA_W-1:0] writedata,
  input vga_snake_pkg::tile_col_t rd_col,
  input vga_snake_pkg::tile_row_t rd_row,
  output vga_snake_pkg::tile_code_t rd_tile
);

  localparam int WORDS_PER_ROW = `MAP_COLS / 4;

  // word = row * 10 + col / 4, leftmost tile in bits 31:24
  logic [`BUS_DATA_W-1:0] map_mem [`MAP_WORDS];

  logic wr_en;
  logic rd_in_map;
  logic [`BUS_ADDR_W-1:0] rd_word;
  logic [1:0] rd_byte;

  assign wr_en = chipselect && write && (address < `MAP_WORDS);

  // --------------------
  // write port
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `MAP_WORDS; i++) begin
        map_mem[i] <= '0;
      end
    end else if (wr_en) begin
      map_mem[address] <= writedata;
    end
  end

  // --------------------
  // read port
  assign rd_in_map = (rd_col < `MAP_COLS) && (rd_row < `MAP_ROWS);
  assign rd_word = `BUS_ADDR_W'(rd_row) * `BUS_ADDR_W'(WORDS_PER_ROW)
                 + `BUS_ADDR_W'(rd_col[5:2]);
  // column 0 of a group sits in the top byte
  assign rd_byte = ~rd_col[1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_tile <= vga_snake_pkg::TILE_EMPTY;
    end else if (rd_in_map) begin
      rd_tile <= map_mem[rd_word][{rd_byte, 3'b000} +: 8];
    end else begin
      rd_tile <= vga_snake_pkg::TILE_EMPTY;
    end
  end

  // in-map reads stay inside the word array
  a_rd_word_range: assert property (@(posedge clk) disable iff (reset)
    rd_in_map |-> rd_word < `MAP_WORDS);

endmodule

/* tile_renderer.sv */
// --------------------
// two-stage pixel pipeline
// tile lookup, wall border, colour out
// --------------------
`timescale 1ns/1ps
`include "vga_snake_cfg.svh"

module tile_renderer (
  input logic clk,
  input logic reset,
  video_timing_if.sink vt,
  output vga_snake_pkg::tile_col_t rd_col,
  output vga_snake_pkg::tile_row_t rd_row,
  input vga_snake_pkg::tile_code_t rd_tile,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic vga_hs,
  output logic vga_vs,
  output logic vga_blank_n,
  output logic vga_clk
);

  // wall blocks are 32x32 pixels, two tiles on a side
  localparam logic [4:0] RIGHT_BLK = 5'(`MAP_COLS / 2 - 1);
  localparam logic [4:0] BOTTOM_BLK = 5'(`MAP_ROWS / 2 - 1);

  logic [4:0] hblk;
  logic [4:0] vblk;
  logic wall;

  logic wall_q;
  logic hs_q;
  logic vs_q;
  logic blank_q;
  logic clk_q;

  vga_snake_pkg::rgb_t pix;

  // --------------------
  // stage one
  assign rd_col = vt.hcount[10:5];
  assign rd_row = vt.vcount[8:4];

  assign hblk = vt.hcount[10:6];
  assign vblk = vt.vcount[9:5];

  // top row is block row 1, side columns start below it
  always_comb begin
    wall = 1'b0;
    if (vblk == 5'd1 || vblk == BOTTOM_BLK) begin
      wall = 1'b1;
    end else if (vblk > 5'd1 && (hblk == 5'd0 || hblk == RIGHT_BLK)) begin
      wall = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wall_q <= 1'b0;
      hs_q <= 1'b1;
      vs_q <= 1'b1;
      blank_q <= 1'b1;
      clk_q <= 1'b0;
    end else begin
      wall_q <= wall;
      hs_q <= vt.hs;
      vs_q <= vt.vs;
      blank_q <= vt.blank_n;
      clk_q <= vt.hcount[0];
    end
  end

  // --------------------
  // stage two
  assign pix = blank_q ? vga_snake_pkg::tile_color(rd_tile, wall_q) : '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_blank_n <= 1'b1;
      vga_clk <= 1'b0;
    end else begin
      vga_r <= pix.r;
      vga_g <= pix.g;
      vga_b <= pix.b;
      vga_hs <= hs_q;
      vga_vs <= vs_q;
      vga_blank_n <= blank_q;
      vga_clk <= clk_q;
    end
  end

  a_blank_black: assert property (@(posedge clk) disable iff (reset)
    !vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'd0);

endmodule

/* vga_snake.sv */
// --------------------
// snake tile display top level
// bus writes in, VGA pins out
// --------------------
`timescale 1ns/1ps
`include "vga_snake_cfg.svh"

module vga_snake (
  input logic clk,
  input logic reset,
  input logic [`BUS_DATA_W-1:0] writedata,
  input logic write,
  input logic chipselect,
  input logic [`BUS_ADDR_W-1:0] address,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic vga_clk,
  output logic vga_hs,
  output logic vga_vs,
  output logic vga_blank_n,
  output logic vga_sync_n
);

  vga_snake_pkg::tile_col_t rd_col;
  vga_snake_pkg::tile_row_t rd_row;
  vga_snake_pkg::tile_code_t rd_tile;

  video_timing_if vt ();

  vga_timing u_timing (
    .clk (clk),
    .reset (reset),
    .vt (vt)
  );

  tile_map u_map (
    .clk (clk),
    .reset (reset),
    .chipselect (chipselect),
    .write (write),
    .address (address),
    .writedata (writedata),
    .rd_col (rd_col),
    .rd_row (rd_row),
    .rd_tile (rd_tile)
  );

  tile_renderer u_renderer (
    .clk (clk),
    .reset (reset),
    .vt (vt),
    .rd_col (rd_col),
    .rd_row (rd_row),
    .rd_tile (rd_tile),
    .vga_r (vga_r),
    .vga_g (vga_g),
    .vga_b (vga_b),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs),
    .vga_blank_n (vga_blank_n),
    .vga_clk (vga_clk)
  );

  // no sync on green
  assign vga_sync_n = 1'b0;

endmodule

/* tb_clock_gen.sv */
// --------------------
// testbench clock and reset source
// 100 ns clock, reset held 8 cycles
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release on a falling edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  end

endmodule

/* tb_vga_snake.sv */
// --------------------
// testbench for the snake tile display
// map write table, shadow map, and a
// cycle model of sync and colour output
// --------------------
`timescale 1ns/1ps
`include "vga_snake_cfg.svh"

module tb_vga_snake;

  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END = VS_START + `V_SYNC;
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int WORDS_PER_ROW = `MAP_COLS / 4;
  localparam int LAST_BLK_COL = `MAP_COLS / 2 - 1;
  localparam int LAST_BLK_ROW = `MAP_ROWS / 2 - 1;
  localparam int NUM_WRITES = 12;
  localparam int NUM_RANDOM = 12;

  typedef struct packed {
    vga_snake_pkg::rgb_t rgb;
    logic hs;
    logic vs;
    logic blank_n;
    logic vclk;
  } pix_exp_t;

  typedef struct packed {
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] data;
    logic cs;
    logic wr;
    logic [5:0] col;
    logic [4:0] row;
    logic [7:0] kind;
  } map_write_t;

  localparam pix_exp_t RESET_PIX = '{rgb: '0, hs: 1'b1, vs: 1'b1, blank_n: 1'b1, vclk: 1'b0};

  // addr, data, chipselect, write, then the tile to look at and its kind
  localparam map_write_t WRITE_TABLE [NUM_WRITES] = '{
    '{9'd12, 32'h0102_0300, 1'b1, 1'b1, 6'd9, 5'd1, 8'h02},
    '{9'd55, 32'h0000_0001, 1'b1, 1'b1, 6'd23, 5'd5, 8'h01},
    '{9'd101, 32'h0303_0302, 1'b1, 1'b1, 6'd7, 5'd10, 8'h02},
    '{9'd20, 32'h0201_0303, 1'b1, 1'b1, 6'd1, 5'd2, 8'h01},
    '{9'd150, 32'h0300_0000, 1'b1, 1'b1, 6'd0, 5'd15, 8'h03},
    '{9'd209, 32'h0000_0102, 1'b1, 1'b1, 6'd39, 5'd20, 8'h02},
    '{9'd294, 32'h0107_ff03, 1'b1, 1'b1, 6'd18, 5'd29, 8'hff},
    '{9'd55, 32'h0000_0000, 1'b0, 1'b1, 6'd23, 5'd5, 8'h01},
    '{9'd12, 32'h0000_0000, 1'b1, 1'b0, 6'd9, 5'd1, 8'h02},
    '{9'd300, 32'h0101_0101, 1'b1, 1'b1, 6'd16, 5'd4, 8'h00},
    '{9'd511, 32'h0202_0202, 1'b1, 1'b1, 6'd20, 5'd25, 8'h00},
    '{9'd299, 32'h0302_0100, 1'b1, 1'b1, 6'd36, 5'd29, 8'h03}
  };

  logic clk;
  logic reset;
  logic [`BUS_DATA_W-1:0] writedata;
  logic write;
  logic chipselect;
  logic [`BUS_ADDR_W-1:0] address;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic vga_clk;
  logic vga_hs;
  logic vga_vs;
  logic vga_blank_n;
  logic vga_sync_n;

  int seed;
  logic compare_on;

  vga_snake_pkg::hcount_t m_h;
  vga_snake_pkg::vcount_t m_v;
  pix_exp_t exp_s1;
  pix_exp_t exp_q;
  logic [7:0] shadow [`MAP_ROWS][`MAP_COLS];

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .reset (reset)
  );

  vga_snake u_vga_snake (
    .clk (clk),
    .reset (reset),
    .writedata (writedata),
    .write (write),
    .chipselect (chipselect),
    .address (address),
    .vga_r (vga_r),
    .vga_g (vga_g),
    .vga_b (vga_b),
    .vga_clk (vga_clk),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs),
    .vga_blank_n (vga_blank_n),
    .vga_sync_n (vga_sync_n)
  );

  // --------------------
  // reporting
  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("** Error at %0t: %s expected %0h, got %0h",
                          $time, name, expected, actual));
    end
  endtask

  // --------------------
  // reference model
  function automatic vga_snake_pkg::rgb_t palette(logic [7:0] code, logic wall);
    case (code)
      8'd1: return {8'd248, 8'd0, 8'd0};
      8'd2: return {8'd0, 8'd252, 8'd0};
      8'd3: return {8'd0, 8'd128, 8'd0};
      default: return wall ? {8'd128, 8'd128, 8'd128} : 24'd0;
    endcase
  endfunction

  function automatic pix_exp_t model_pixel(int h, int v);
    pix_exp_t p;
    int px;
    int bx;
    int by;
    logic wall;
    p.hs = !(h >= HS_START && h < HS_END);
    p.vs = !(v >= VS_START && v < VS_END);
    p.blank_n = (h < `H_ACTIVE) && (v < `V_ACTIVE);
    p.vclk = (h % 2) == 1;
    p.rgb = '0;
    if (p.blank_n) begin
      px = h / 2;
      bx = px / 32;
      by = v / 32;
      wall = (by == 1) || (by == LAST_BLK_ROW) || (by > 1 && (bx == 0 || bx == LAST_BLK_COL));
      p.rgb = palette(shadow[v / 16][px / 16], wall);
    end
    return p;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      m_h <= '0;
      m_v <= '0;
      exp_s1 <= RESET_PIX;
      exp_q <= RESET_PIX;
      for (int r = 0; r < `MAP_ROWS; r++) begin
        for (int c = 0; c < `MAP_COLS; c++) begin
          shadow[r][c] <= 8'd0;
        end
      end
    end else begin
      // lookup sees the map as it was before this edge
      exp_s1 <= model_pixel(m_h, m_v);
      exp_q <= exp_s1;
      if (chipselect && write && address < `MAP_WORDS) begin
        for (int k = 0; k < 4; k++) begin
          shadow[address / WORDS_PER_ROW][(address % WORDS_PER_ROW) * 4 + k]
            <= writedata[31 - 8 * k -: 8];
        end
      end
      if (m_h == `H_TOTAL - 1) begin
        m_h <= '0;
        m_v <= (m_v == `V_TOTAL - 1) ? '0 : m_v + 10'd1;
      end else begin
        m_h <= m_h + 11'd1;
      end
    end
  end

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (compare_on) begin
      check_value("vga_r", exp_q.rgb.r, vga_r);
      check_value("vga_g", exp_q.rgb.g, vga_g);
      check_value("vga_b", exp_q.rgb.b, vga_b);
      check_value("vga_hs", exp_q.hs, vga_hs);
      check_value("vga_vs", exp_q.vs, vga_vs);
      check_value("vga_blank_n", exp_q.blank_n, vga_blank_n);
      check_value("vga_clk", exp_q.vclk, vga_clk);
      check_value("vga_sync_n", 0, vga_sync_n);
    end
  end

  // --------------------
  // stimulus
  task automatic bus_write(logic [8:0] addr, logic [31:0] data, logic cs, logic wr);
    @(negedge clk);
    address = addr;
    writedata = data;
    chipselect = cs;
    write = wr;
  endtask

  task automatic bus_idle();
    @(negedge clk);
    chipselect = 1'b0;
    write = 1'b0;
  endtask

  task automatic wait_for_reset_release(int limit);
    int n;
    n = 0;
    while (reset) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        abort_run("reset was never released");
      end
    end
  endtask

  task automatic wait_for_line(int line, int limit);
    int n;
    n = 0;
    while (m_v != line) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        abort_run($sformatf("beam never reached line %0d", line));
      end
    end
  endtask

  task automatic apply_table();
    for (int i = 0; i < NUM_WRITES; i++) begin
      bus_write(WRITE_TABLE[i].addr, WRITE_TABLE[i].data, WRITE_TABLE[i].cs,
                WRITE_TABLE[i].wr);
    end
    bus_idle();
    for (int i = 0; i < NUM_WRITES; i++) begin
      check_value($sformatf("map tile col %0d row %0d", WRITE_TABLE[i].col,
                            WRITE_TABLE[i].row),
                  WRITE_TABLE[i].kind, shadow[WRITE_TABLE[i].row][WRITE_TABLE[i].col]);
    end
  endtask

  // random codes reach well past 3, which must draw as empty or wall
  task automatic apply_random_writes();
    logic [8:0] addr;
    logic [31:0] data;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = 9'($unsigned($random(seed)) % `MAP_WORDS);
      data = $random(seed);
      bus_write(addr, data, 1'b1, 1'b1);
    end
    bus_idle();
  endtask

  initial begin
    seed = 48529;
    compare_on = 1'b0;
    address = '0;
    writedata = '0;
    write = 1'b0;
    chipselect = 1'b0;

    // levels held while in reset
    @(negedge clk);
    check_value("vga_hs", 1, vga_hs);
    check_value("vga_vs", 1, vga_vs);
    check_value("vga_blank_n", 1, vga_blank_n);
    check_value("vga_r", 0, vga_r);
    check_value("vga_g", 0, vga_g);
    check_value("vga_b", 0, vga_b);
    check_value("vga_sync_n", 0, vga_sync_n);
    compare_on = 1'b1;
    wait_for_reset_release(20);

    // first frame runs on the empty map
    wait_for_line(`V_ACTIVE, FRAME_CYCLES + 16);
    apply_table();
    apply_random_writes();

    // second frame shows the written tiles
    wait_for_line(0, FRAME_CYCLES + 16);
    wait_for_line(`V_ACTIVE, FRAME_CYCLES + 16);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
vga_snake_pkg.sv
video_timing_if.sv
vga_timing.sv
tile_map.sv
tile_renderer.sv
vga_snake.sv
tb_clock_gen.sv
tb_vga_snake.sv

/* Bender.yml */
package:
  name: vga_snake

export_include_dirs:
  - .

sources:
  - files:
      - vga_snake_pkg.sv
      - video_timing_if.sv
      - vga_timing.sv
      - tile_map.sv
      - tile_renderer.sv
      - vga_snake.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_vga_snake.sv
